/* vlog.f */
+incdir+hw
hw/ubuf_pkg.sv
hw/tile_loader.sv
hw/local_buf.sv
hw/ubuf_ctrl.sv
hw/ubuf_top.sv
dv/tb_clk_gen.sv
dv/ubuf_sva.sv
dv/ubuf_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps --top-module ubuf_tb \
    -f vlog.f -o ubuf_sim \
    && ./obj_dir/ubuf_sim 2>&1 | tee sim.log
grep -qs "All tests passed" sim.log || { echo "simulation did not pass"; exit 1; }
echo "simulation passed"

/* dv/ubuf_stim.txt */
// each image block is mem select (1 = A, 2 = B) then base then count then the words
// after the 0000 end marker each operation has its eight config words
// (a_src a_ch a_row a_col b_src b_ch b_row b_col)
// followed by the expected unified buffer words and the expected weight buffer words
0001 000F 0008
DEAD 1A01 2B02 3C03 4D04 5E05 6F06 BEEF
0002 00FF 000A
0BAD 7001 7102 7203 7304 7405 7506 7607
7708 0FAB
0001 07FA 000C
C0DE 8811 8922 8A33 8B44 8C55 8D66 8E77
8F88 9099 91AA F00D
0002 009F 000B
1357 A0B1 A1B2 A2B3 A3B4 A4B5 A5B6 A6B7
A7B8 A8B9 2468
0000
// first operation
0010 0001 0002 0003 0100 0002 0002 0002
1A01 2B02 3C03 4D04 5E05 6F06
7001 7102 7203 7304 7405 7506 7607 7708
// second operation, A tile crosses 0x800
07FB 0001 0002 0005 00A0 0003 0003 0001
8811 8922 8A33 8B44 8C55 8D66 8E77 8F88
9099 91AA
A0B1 A1B2 A2B3 A3B4 A4B5 A5B6 A6B7 A7B8
A8B9

/* dv/ubuf_tb.sv */
`timescale 1ns/100ps

module ubuf_tb;

    localparam int STIM_WORDS = 103;
    localparam int MEM_DEPTH  = 2 ** $bits(ubuf_pkg::word_addr_t);
    localparam int ACK_LIMIT  = 20;
    localparam int LOAD_LIMIT = 600;
    localparam int RST_LIMIT  = 10;

    logic                 clk;
    logic                 rst;
    logic                 config_valid;
    ubuf_pkg::ubuf_op_e   op;
    ubuf_pkg::word_addr_t a_src_addr;
    ubuf_pkg::dim_t       a_channel;
    ubuf_pkg::dim_t       a_row;
    ubuf_pkg::dim_t       a_col;
    ubuf_pkg::word_addr_t b_src_addr;
    ubuf_pkg::dim_t       b_channel;
    ubuf_pkg::dim_t       b_row;
    ubuf_pkg::dim_t       b_col;
    logic                 ack;
    logic                 a_ren;
    ubuf_pkg::word_addr_t a_addr;
    ubuf_pkg::word_t      a_rdata;
    logic                 b_ren;
    ubuf_pkg::word_addr_t b_addr;
    ubuf_pkg::word_t      b_rdata;
    logic                 sys_done;
    logic                 sys_uni_ready;
    ubuf_pkg::buf_addr_t  sys_uni_addr;
    ubuf_pkg::word_t      sys_uni_data;
    logic                 sys_wei_ready;
    ubuf_pkg::buf_addr_t  sys_wei_addr;
    ubuf_pkg::word_t      sys_wei_data;

    ubuf_pkg::word_t stim [STIM_WORDS];
    ubuf_pkg::word_t mem_a [MEM_DEPTH];
    ubuf_pkg::word_t mem_b [MEM_DEPTH];
    int              op_pos [2];

    tb_clk_gen clk_gen_i (
        .clk (clk),
        .rst (rst)
    );

    ubuf_top i_ubuf_top (.*);

    // external memories A and B with one cycle read latency
    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            a_rdata <= '0;
            b_rdata <= '0;
        end else begin
            if (a_ren) begin
                a_rdata <= mem_a[a_addr];
            end
            if (b_ren) begin
                b_rdata <= mem_b[b_addr];
            end
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input ubuf_pkg::word_t got,
                              input ubuf_pkg::word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // channel * row * col of the shape starting one word after pos
    function automatic int tile_size(input int pos);
        return int'(stim[pos + 1]) * int'(stim[pos + 2]) * int'(stim[pos + 3]);
    endfunction

    // address pattern everywhere with the image blocks on top
    task automatic load_memories(output int pos);
        int sel;
        int base;
        int cnt;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            mem_a[i] = {4'hA, ubuf_pkg::word_addr_t'(i)};
            mem_b[i] = {4'h5, ~ubuf_pkg::word_addr_t'(i)};
        end
        pos = 0;
        while (pos < STIM_WORDS && stim[pos] != '0) begin
            sel  = int'(stim[pos]);
            base = int'(stim[pos + 1]);
            cnt  = int'(stim[pos + 2]);
            for (int k = 0; k < cnt; k++) begin
                if (sel == 1) begin
                    mem_a[ubuf_pkg::word_addr_t'(base + k)] = stim[pos + 3 + k];
                end else begin
                    mem_b[ubuf_pkg::word_addr_t'(base + k)] = stim[pos + 3 + k];
                end
            end
            pos = pos + 3 + cnt;
        end
        pos = pos + 1;
    endtask

    task automatic drive_fields(input int pos);
        a_src_addr = ubuf_pkg::word_addr_t'(stim[pos]);
        a_channel  = ubuf_pkg::dim_t'(stim[pos + 1]);
        a_row      = ubuf_pkg::dim_t'(stim[pos + 2]);
        a_col      = ubuf_pkg::dim_t'(stim[pos + 3]);
        b_src_addr = ubuf_pkg::word_addr_t'(stim[pos + 4]);
        b_channel  = ubuf_pkg::dim_t'(stim[pos + 5]);
        b_row      = ubuf_pkg::dim_t'(stim[pos + 6]);
        b_col      = ubuf_pkg::dim_t'(stim[pos + 7]);
    endtask

    task automatic host_request(input ubuf_pkg::ubuf_op_e code, input int pos,
                                input logic expect_ack);
        int waited;
        @(negedge clk);
        config_valid = 1'b1;
        op           = code;
        drive_fields(pos);
        if (expect_ack) begin
            for (waited = 1; waited <= ACK_LIMIT; waited++) begin
                @(negedge clk);
                if (ack) break;
            end
            if (!ack) begin
                fail_run($sformatf("no ack for opcode %0d within %0d cycles",
                                   int'(code), ACK_LIMIT));
            end
            if (waited != 1) begin
                fail_run($sformatf("ack came %0d cycles after the request", waited));
            end
        end else begin
            repeat (ACK_LIMIT) begin
                @(negedge clk);
                check_bit("ack", ack, 1'b0);
            end
        end
        config_valid = 1'b0;
    endtask

    task automatic wait_ready();
        int waited;
        for (waited = 0; waited < LOAD_LIMIT; waited++) begin
            @(negedge clk);
            if (sys_uni_ready) break;
        end
        if (!sys_uni_ready) begin
            fail_run($sformatf("buffers not ready within %0d cycles", LOAD_LIMIT));
        end
        check_bit("sys_wei_ready", sys_wei_ready, 1'b1);
    endtask

    // every index once in shuffled order
    task automatic read_back(input logic wei, input int exp_pos, input int n);
        int order [$];
        int pick;
        int tmp;
        for (int i = 0; i < n; i++) begin
            order.push_back(i);
        end
        for (int i = n - 1; i > 0; i--) begin
            pick       = int'($urandom_range(i, 0));
            tmp        = order[i];
            order[i]   = order[pick];
            order[pick] = tmp;
        end
        foreach (order[k]) begin
            @(negedge clk);
            if (wei) begin
                sys_wei_addr = ubuf_pkg::buf_addr_t'(order[k]);
            end else begin
                sys_uni_addr = ubuf_pkg::buf_addr_t'(order[k]);
            end
            @(negedge clk);
            if (wei) begin
                check_word("sys_wei_data", sys_wei_data, stim[exp_pos + order[k]]);
            end else begin
                check_word("sys_uni_data", sys_uni_data, stim[exp_pos + order[k]]);
            end
        end
    endtask

    // the OP_MAT request shows other fields than the stored configuration
    task automatic run_tile(input int pos, input int bus_pos);
        host_request(ubuf_pkg::OP_MAT, bus_pos, 1'b1);
        wait_ready();
        read_back(1'b0, pos + 8, tile_size(pos));
        read_back(1'b1, pos + 8 + tile_size(pos), tile_size(pos + 4));
    endtask

    task automatic finish_op();
        @(negedge clk);
        sys_done = 1'b1;
        @(negedge clk);
        sys_done = 1'b0;
        check_bit("sys_uni_ready", sys_uni_ready, 1'b0);
        check_bit("sys_wei_ready", sys_wei_ready, 1'b0);
        @(negedge clk);
        check_word("sys_uni_data", sys_uni_data, '0);
        check_word("sys_wei_data", sys_wei_data, '0);
    endtask

    initial begin
        int pos;
        void'($urandom(56707));
        config_valid = 1'b0;
        op           = ubuf_pkg::OP_CONFIG;
        sys_done     = 1'b0;
        sys_uni_addr = '0;
        sys_wei_addr = '0;
        $readmemh("dv/ubuf_stim.txt", stim);
        load_memories(pos);
        op_pos[0] = pos;
        op_pos[1] = pos + 8 + tile_size(pos) + tile_size(pos + 4);
        drive_fields(op_pos[0]);
        if (op_pos[1] + 8 + tile_size(op_pos[1]) + tile_size(op_pos[1] + 4) != STIM_WORDS) begin
            fail_run("stim file length does not match its tile shapes");
        end

        for (int i = 0; i < RST_LIMIT && rst !== 1'b1; i++) begin
            @(posedge clk);
        end
        if (rst !== 1'b1) begin
            fail_run("reset was never released");
        end
        @(negedge clk);
        check_bit("ack", ack, 1'b0);
        check_bit("sys_uni_ready", sys_uni_ready, 1'b0);
        check_bit("sys_wei_ready", sys_wei_ready, 1'b0);
        check_bit("a_ren", a_ren, 1'b0);
        check_bit("b_ren", b_ren, 1'b0);
        check_word("sys_uni_data", sys_uni_data, '0);
        check_word("sys_wei_data", sys_wei_data, '0);

        host_request(ubuf_pkg::OP_CONFIG, op_pos[0], 1'b1);
        @(negedge clk);
        check_bit("sys_uni_ready", sys_uni_ready, 1'b0);
        check_bit("sys_wei_ready", sys_wei_ready, 1'b0);
        // convolution is decoded but never acknowledged
        host_request(ubuf_pkg::OP_CONV, op_pos[0], 1'b0);
        run_tile(op_pos[0], op_pos[1]);
        // array still owns the buffers
        host_request(ubuf_pkg::OP_CONFIG, op_pos[1], 1'b0);
        finish_op();

        host_request(ubuf_pkg::OP_CONFIG, op_pos[1], 1'b1);
        run_tile(op_pos[1], op_pos[0]);
        finish_op();

        $display("All tests passed");
        $finish;
    end

endmodule

/* dv/ubuf_sva.sv */
`timescale 1ns/100ps

module ubuf_sva (
    input logic           clk,
    input logic           rst,
    input logic           ack,
    input logic           a_ren,
    input logic           sys_uni_ready,
    input logic           sys_wei_ready,
    input logic           load_start,
    input ubuf_pkg::dim_t a_dims_channel,
    input ubuf_pkg::dim_t a_dims_row,
    input ubuf_pkg::dim_t a_dims_col,
    input ubuf_pkg::dim_t b_dims_channel,
    input ubuf_pkg::dim_t b_dims_row,
    input ubuf_pkg::dim_t b_dims_col
);

    localparam int BUF_DEPTH = 2 ** $bits(ubuf_pkg::buf_addr_t);

    int a_words;
    int b_words;

    assign a_words = int'(a_dims_channel) * int'(a_dims_row) * int'(a_dims_col);
    assign b_words = int'(b_dims_channel) * int'(b_dims_row) * int'(b_dims_col);

    ack_pulse: assert property (@(posedge clk) disable iff (!rst) ack |=> !ack)
        else $error("ack held high for two cycles");

    ready_pair: assert property (@(posedge clk) disable iff (!rst)
        sys_uni_ready == sys_wei_ready)
        else $error("unified and weight ready differ");

    // no external fetch while the array owns the buffers
    quiet_serve: assert property (@(posedge clk) disable iff (!rst) sys_uni_ready |-> !a_ren)
        else $error("a_ren active while the buffers are ready");

    tile_fits: assert property (@(posedge clk) disable iff (!rst)
        load_start |-> (a_words <= BUF_DEPTH && b_words <= BUF_DEPTH))
        else $error("tile larger than the local buffer at load start");

endmodule

bind ubuf_top ubuf_sva sva_i (
    .clk            (clk),
    .rst            (rst),
    .ack            (ack),
    .a_ren          (a_ren),
    .sys_uni_ready  (sys_uni_ready),
    .sys_wei_ready  (sys_wei_ready),
    .load_start     (load_start),
    .a_dims_channel (a_dims_channel),
    .a_dims_row     (a_dims_row),
    .a_dims_col     (a_dims_col),
    .b_dims_channel (b_dims_channel),
    .b_dims_row     (b_dims_row),
    .b_dims_col     (b_dims_col)
);

/* dv/tb_clk_gen.sv */
`timescale 1ns/100ps

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    localparam int HALF = 5;

    initial begin
        clk = 1'b0;
        forever #HALF clk = ~clk;
    end

    // reset low for two cycles, released on a falling edge
    initial begin
        rst = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
    end

endmodule

/* hw/ubuf_top.sv */
`timescale 1ns/100ps

module ubuf_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 config_valid,
    input  ubuf_pkg::ubuf_op_e   op,
    input  ubuf_pkg::word_addr_t a_src_addr,
    input  ubuf_pkg::dim_t       a_channel,
    input  ubuf_pkg::dim_t       a_row,
    input  ubuf_pkg::dim_t       a_col,
    input  ubuf_pkg::word_addr_t b_src_addr,
    input  ubuf_pkg::dim_t       b_channel,
    input  ubuf_pkg::dim_t       b_row,
    input  ubuf_pkg::dim_t       b_col,
    output logic                 ack,
    output logic                 a_ren,
    output ubuf_pkg::word_addr_t a_addr,
    input  ubuf_pkg::word_t      a_rdata,
    output logic                 b_ren,
    output ubuf_pkg::word_addr_t b_addr,
    input  ubuf_pkg::word_t      b_rdata,
    input  logic                 sys_done,
    output logic                 sys_uni_ready,
    input  ubuf_pkg::buf_addr_t  sys_uni_addr,
    output ubuf_pkg::word_t      sys_uni_data,
    output logic                 sys_wei_ready,
    input  ubuf_pkg::buf_addr_t  sys_wei_addr,
    output ubuf_pkg::word_t      sys_wei_data
);

    logic                 load_start;
    logic                 serve;
    logic                 uni_loaded;
    logic                 wei_loaded;
    ubuf_pkg::word_addr_t a_base;
    ubuf_pkg::word_addr_t b_base;
    ubuf_pkg::dim_t       a_dims_channel;
    ubuf_pkg::dim_t       a_dims_row;
    ubuf_pkg::dim_t       a_dims_col;
    ubuf_pkg::dim_t       b_dims_channel;
    ubuf_pkg::dim_t       b_dims_row;
    ubuf_pkg::dim_t       b_dims_col;

    logic                 uni_wen;
    ubuf_pkg::buf_addr_t  uni_waddr;
    ubuf_pkg::word_t      uni_wdata;
    logic                 wei_wen;
    ubuf_pkg::buf_addr_t  wei_waddr;
    ubuf_pkg::word_t      wei_wdata;

    ubuf_ctrl ctrl_i (
        .clk            (clk),
        .rst            (rst),
        .config_valid   (config_valid),
        .op             (op),
        .a_src_addr     (a_src_addr),
        .a_channel      (a_channel),
        .a_row          (a_row),
        .a_col          (a_col),
        .b_src_addr     (b_src_addr),
        .b_channel      (b_channel),
        .b_row          (b_row),
        .b_col          (b_col),
        .ack            (ack),
        .sys_done       (sys_done),
        .uni_loaded     (uni_loaded),
        .wei_loaded     (wei_loaded),
        .load_start     (load_start),
        .a_base         (a_base),
        .b_base         (b_base),
        .a_dims_channel (a_dims_channel),
        .a_dims_row     (a_dims_row),
        .a_dims_col     (a_dims_col),
        .b_dims_channel (b_dims_channel),
        .b_dims_row     (b_dims_row),
        .b_dims_col     (b_dims_col),
        .serve          (serve)
    );

    // operand A into the unified buffer
    tile_loader uni_loader_i (
        .clk     (clk),
        .rst     (rst),
        .start   (load_start),
        .base    (a_base),
        .channel (a_dims_channel),
        .row     (a_dims_row),
        .col     (a_dims_col),
        .ren     (a_ren),
        .addr    (a_addr),
        .rdata   (a_rdata),
        .wen     (uni_wen),
        .waddr   (uni_waddr),
        .wdata   (uni_wdata),
        .loaded  (uni_loaded)
    );

    // weights into the weight buffer
    tile_loader wei_loader_i (
        .clk     (clk),
        .rst     (rst),
        .start   (load_start),
        .base    (b_base),
        .channel (b_dims_channel),
        .row     (b_dims_row),
        .col     (b_dims_col),
        .ren     (b_ren),
        .addr    (b_addr),
        .rdata   (b_rdata),
        .wen     (wei_wen),
        .waddr   (wei_waddr),
        .wdata   (wei_wdata),
        .loaded  (wei_loaded)
    );

    local_buf uni_buf_i (
        .clk   (clk),
        .rst   (rst),
        .wen   (uni_wen),
        .waddr (uni_waddr),
        .wdata (uni_wdata),
        .serve (serve),
        .raddr (sys_uni_addr),
        .rdata (sys_uni_data)
    );

    local_buf wei_buf_i (
        .clk   (clk),
        .rst   (rst),
        .wen   (wei_wen),
        .waddr (wei_waddr),
        .wdata (wei_wdata),
        .serve (serve),
        .raddr (sys_wei_addr),
        .rdata (sys_wei_data)
    );

    // both buffers open to the array together
    assign sys_uni_ready = serve;
    assign sys_wei_ready = serve;

endmodule

/* hw/ubuf_ctrl.sv */
`timescale 1ns/100ps

module ubuf_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 config_valid,
    input  ubuf_pkg::ubuf_op_e   op,
    input  ubuf_pkg::word_addr_t a_src_addr,
    input  ubuf_pkg::dim_t       a_channel,
    input  ubuf_pkg::dim_t       a_row,
    input  ubuf_pkg::dim_t       a_col,
    input  ubuf_pkg::word_addr_t b_src_addr,
    input  ubuf_pkg::dim_t       b_channel,
    input  ubuf_pkg::dim_t       b_row,
    input  ubuf_pkg::dim_t       b_col,
    output logic                 ack,
    input  logic                 sys_done,
    input  logic                 uni_loaded,
    input  logic                 wei_loaded,
    output logic                 load_start,
    output ubuf_pkg::word_addr_t a_base,
    output ubuf_pkg::word_addr_t b_base,
    output ubuf_pkg::dim_t       a_dims_channel,
    output ubuf_pkg::dim_t       a_dims_row,
    output ubuf_pkg::dim_t       a_dims_col,
    output ubuf_pkg::dim_t       b_dims_channel,
    output ubuf_pkg::dim_t       b_dims_row,
    output ubuf_pkg::dim_t       b_dims_col,
    output logic                 serve
);

    ubuf_pkg::ctrl_state_e state_q;
    logic                  is_config;
    logic                  is_mat;
    logic                  accept;

    always_comb begin
        is_config = 1'b0;
        is_mat    = 1'b0;
        case (op)
            ubuf_pkg::OP_CONFIG: is_config = 1'b1;
            ubuf_pkg::OP_MAT:    is_mat    = 1'b1;
            // convolution is not built, the host times out
            ubuf_pkg::OP_CONV:   ;
            default:             ;
        endcase
    end

    // one ack per request even if the host is slow to drop valid
    assign accept = config_valid && !ack && (state_q == ubuf_pkg::ST_IDLE)
                    && (is_config || is_mat);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q    <= ubuf_pkg::ST_IDLE;
            ack        <= 1'b0;
            load_start <= 1'b0;
        end else begin
            ack        <= accept;
            load_start <= accept && is_mat;
            case (state_q)
                ubuf_pkg::ST_IDLE: begin
                    if (accept && is_mat) begin
                        state_q <= ubuf_pkg::ST_LOAD;
                    end
                end
                ubuf_pkg::ST_LOAD: begin
                    // loaded flags still show the old tile during the start pulse
                    if (uni_loaded && wei_loaded && !load_start) begin
                        state_q <= ubuf_pkg::ST_SERVE;
                    end
                end
                ubuf_pkg::ST_SERVE: begin
                    if (sys_done) begin
                        state_q <= ubuf_pkg::ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ubuf_pkg::ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept && is_config) begin
            a_base         <= a_src_addr;
            a_dims_channel <= a_channel;
            a_dims_row     <= a_row;
            a_dims_col     <= a_col;
            b_base         <= b_src_addr;
            b_dims_channel <= b_channel;
            b_dims_row     <= b_row;
            b_dims_col     <= b_col;
        end
    end

    assign serve = (state_q == ubuf_pkg::ST_SERVE);

endmodule

/* hw/local_buf.sv */
`timescale 1ns/100ps

module local_buf (
    input  logic                clk,
    input  logic                rst,
    input  logic                wen,
    input  ubuf_pkg::buf_addr_t waddr,
    input  ubuf_pkg::word_t     wdata,
    input  logic                serve,
    input  ubuf_pkg::buf_addr_t raddr,
    output ubuf_pkg::word_t     rdata
);

    localparam int DEPTH = 2 ** $bits(ubuf_pkg::buf_addr_t);

    ubuf_pkg::word_t mem [DEPTH];

    // loader side
    always_ff @(posedge clk) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    // systolic side, zero outside the serve window
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rdata <= '0;
        end else if (serve) begin
            rdata <= mem[raddr];
        end else begin
            rdata <= '0;
        end
    end

endmodule

/* hw/tile_loader.sv */
`timescale 1ns/100ps

module tile_loader (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  ubuf_pkg::word_addr_t base,
    input  ubuf_pkg::dim_t       channel,
    input  ubuf_pkg::dim_t       row,
    input  ubuf_pkg::dim_t       col,
    output logic                 ren,
    output ubuf_pkg::word_addr_t addr,
    input  ubuf_pkg::word_t      rdata,
    output logic                 wen,
    output ubuf_pkg::buf_addr_t  waddr,
    output ubuf_pkg::word_t      wdata,
    output logic                 loaded
);

    localparam int DIM_W  = $bits(ubuf_pkg::dim_t);
    localparam int BUF_AW = $bits(ubuf_pkg::buf_addr_t);

    typedef logic [3*DIM_W-1:0] prod_t;
    typedef logic [BUF_AW:0]    cnt_t;

    prod_t                tile_prod;
    cnt_t                 tile_words;
    cnt_t                 issue_total;
    cnt_t                 rd_idx;
    cnt_t                 rd_idx_nxt;
    logic                 last_issue;

    logic                 busy_q;
    cnt_t                 rd_idx_q;
    cnt_t                 total_q;
    ubuf_pkg::word_addr_t base_q;
    logic                 wen_q;
    logic                 last_q;
    ubuf_pkg::buf_addr_t  waddr_q;

    // word count, only the low 9 bits are kept
    assign tile_prod  = prod_t'(channel) * prod_t'(row) * prod_t'(col);
    assign tile_words = tile_prod[BUF_AW:0];

    // first read leaves in the start cycle itself
    assign rd_idx      = start ? '0 : rd_idx_q;
    assign issue_total = start ? tile_words : total_q;
    assign rd_idx_nxt  = rd_idx + cnt_t'(1);
    assign ren         = start ? (tile_words != '0) : busy_q;
    assign addr        = (start ? base : base_q) + ubuf_pkg::word_addr_t'(rd_idx);
    assign last_issue  = ren && (rd_idx_nxt == issue_total);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy_q   <= 1'b0;
            rd_idx_q <= '0;
            wen_q    <= 1'b0;
            last_q   <= 1'b0;
            loaded   <= 1'b0;
        end else begin
            if (ren) begin
                rd_idx_q <= rd_idx_nxt;
            end
            busy_q <= ren && !last_issue;
            // write stage lines up with the sram read latency
            wen_q  <= ren;
            last_q <= last_issue;
            if (start) begin
                // an empty tile is done at once
                loaded <= (tile_words == '0);
            end else if (wen_q && last_q) begin
                loaded <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            base_q  <= base;
            total_q <= tile_words;
        end
        waddr_q <= rd_idx[BUF_AW-1:0];
    end

    assign wen   = wen_q;
    assign waddr = waddr_q;
    assign wdata = rdata;

endmodule

/* hw/ubuf_pkg.sv */
`include "ubuf_cfg.svh"

package ubuf_pkg;

    typedef logic [`UBUF_WORD_SIZE-1:0]      word_t;
    typedef logic [`UBUF_WORD_ADDR_BITS-1:0] word_addr_t;
    typedef logic [`UBUF_DATA_MAX_BITS-1:0]  dim_t;
    typedef logic [`UBUF_BUF_ADDR_BITS-1:0]  buf_addr_t;

    // host request opcodes
    typedef enum logic [2:0] {
        OP_CONFIG = 3'd0,
        OP_CONV   = 3'd1,
        OP_MAT    = 3'd2
    } ubuf_op_e;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_LOAD  = 2'd1,
        ST_SERVE = 2'd2
    } ctrl_state_e;

endpackage

/* hw/ubuf_cfg.svh */
`ifndef UBUF_CFG_SVH
`define UBUF_CFG_SVH

// data word width
`define UBUF_WORD_SIZE 16

// external word memory address width
`define UBUF_WORD_ADDR_BITS 12

// one tile dimension (channel, row or col)
`define UBUF_DATA_MAX_BITS 8

// local buffer address width, 256 words deep
`define UBUF_BUF_ADDR_BITS 8

`endif
